// File: hdl/adcfifo_pkg.sv
`default_nettype none

package adcfifo_pkg;

  // width of the bytecnt field carried on the host bus
  localparam int BUS_BYTECNT_BITS = 7;

  // register map, only the registers with logic behind them
  typedef enum logic [7:0] {
    ADCREAD                  = 8'h03,
    FIFO_STAT                = 8'h10,
    FAST_FIFO_READ_MODE      = 8'h1b,
    STREAM_SEGMENT_THRESHOLD = 8'h1d,
    ADC_LOW_RES              = 8'h1e,
    FIFO_UNDERFLOW_COUNT     = 8'h1f,
    FIFO_CONFIG              = 8'h21,
    DDR_SINGLE_RW_DATA       = 8'h25,
    DDR_SINGLE_RW_ADDR       = 8'h26
  } reg_addr_e;

  // host register bus, one cycle per byte
  typedef struct packed {
    logic [7:0]                  address;   // compared against reg_addr_e
    logic [BUS_BYTECNT_BITS-1:0] bytecnt;   // byte index, little-endian
    logic [7:0]                  datai;
    logic                        read;
    logic                        write;
  } reg_bus_t;

  // single-word request into the ui_clk domain
  typedef struct packed {
    logic        single_write;  // level, held until done returns
    logic        single_read;
    logic [29:0] address;
    logic [63:0] write_data;
  } mem_req_t;

  // sample FIFO status seen by the register block
  typedef struct packed {
    logic       full;
    logic       empty;
    logic       underflow_flag;   // sticky
    logic       overflow_flag;    // sticky
    logic [7:0] underflow_count;  // saturates at 255
  } fifo_status_t;

  // reset values
  localparam logic [16:0] SEGMENT_THRESHOLD_RESET = 17'd65536;
  localparam logic        USE_DDR_RESET           = 1'b1;
  localparam logic        DATA_SOURCE_RESET       = 1'b1;  // ADC is the default source

endpackage

`default_nettype wire

// File: hdl/cdc_pulse.sv
`timescale 1ns/10ps
`default_nettype none

module cdc_pulse (
  input  wire reset,
  input  wire src_clk,
  input  wire src_pulse,
  input  wire dst_clk,
  output wire dst_pulse
);

  logic       src_toggle;
  logic [2:0] dst_sync;   // [1:0] resolve metastability, [2] holds the old value

  // each source pulse flips the level
  always_ff @(posedge src_clk) begin
    if (reset)
      src_toggle <= 1'b0;
    else if (src_pulse)
      src_toggle <= ~src_toggle;
  end

  always_ff @(posedge dst_clk) begin
    if (reset)
      dst_sync <= 3'b000;
    else
      dst_sync <= {dst_sync[1:0], src_toggle};
  end

  assign dst_pulse = dst_sync[2] ^ dst_sync[1];  // any change is one event

endmodule

`default_nettype wire

// File: hdl/adcfifo_regs.sv
`timescale 1ns/10ps
`default_nettype none

module adcfifo_regs #(
  parameter int BYTECNT_SIZE = 7
) (
  input  wire                       clk_usb,
  input  wire                       reset,
  input  wire adcfifo_pkg::reg_bus_t bus,
  output logic [7:0]                reg_datao,
  input  wire adcfifo_pkg::fifo_status_t fifo_status,
  input  wire [7:0]                 fifo_head,
  output logic                      fifo_rd_en,
  output logic                      clear_fifo_errors,
  output logic                      no_underflow_errors,
  output logic                      low_res,
  output logic                      low_res_lsb,
  output logic [16:0]               stream_segment_threshold,
  output logic                      use_ddr,
  output logic                      data_source_select,
  output adcfifo_pkg::mem_req_t     mem_req,
  input  wire [63:0]                mem_read_data,
  input  wire                       mem_done
);

  import adcfifo_pkg::*;

  logic [BYTECNT_SIZE-1:0] bytecnt;
  logic [23:0]             threshold_bytes;
  logic                    fast_fifo_read_mode;
  logic                    adc_rd;
  logic                    adc_rd_r;
  logic                    rd_first;
  logic                    fifo_rd_en_reg;
  logic                    single_write;
  logic                    single_read;
  logic [29:0]             single_address;
  logic [63:0]             single_write_data;

  assign bytecnt         = bus.bytecnt[BYTECNT_SIZE-1:0];
  assign threshold_bytes = {7'b0, stream_segment_threshold};

  // readback, zero outside a read cycle
  always_comb begin
    reg_datao = 8'h00;
    if (bus.read) begin
      case (bus.address)
        FIFO_STAT: reg_datao = {4'b0, fifo_status.full, fifo_status.overflow_flag,
                                fifo_status.underflow_flag, fifo_status.empty};
        ADCREAD: reg_datao = fifo_head;  // show-ahead head byte
        FAST_FIFO_READ_MODE: reg_datao = {7'b0, fast_fifo_read_mode};
        STREAM_SEGMENT_THRESHOLD: begin
          if (bytecnt < 3)
            reg_datao = threshold_bytes[bytecnt*8 +: 8];
        end
        ADC_LOW_RES: reg_datao = {6'b0, low_res_lsb, low_res};
        FIFO_UNDERFLOW_COUNT: reg_datao = fifo_status.underflow_count;
        FIFO_CONFIG: reg_datao = {6'b0, data_source_select, use_ddr};
        DDR_SINGLE_RW_DATA: begin
          if (bytecnt < 8)
            reg_datao = mem_read_data[bytecnt*8 +: 8];
        end
        DDR_SINGLE_RW_ADDR: reg_datao = {6'b0, single_read, single_write};  // busy bits
        default: reg_datao = 8'h00;
      endcase
    end
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      low_res                  <= 1'b0;
      low_res_lsb              <= 1'b0;
      stream_segment_threshold <= SEGMENT_THRESHOLD_RESET;
      no_underflow_errors      <= 1'b0;
      use_ddr                  <= USE_DDR_RESET;
      data_source_select       <= DATA_SOURCE_RESET;
    end else if (bus.write) begin
      case (bus.address)
        ADC_LOW_RES: {low_res_lsb, low_res} <= bus.datai[1:0];
        STREAM_SEGMENT_THRESHOLD: begin
          case (bytecnt)
            0: stream_segment_threshold[7:0]  <= bus.datai;
            1: stream_segment_threshold[15:8] <= bus.datai;
            2: stream_segment_threshold[16]   <= bus.datai[0];  // only one bit lives up here
            default: ;
          endcase
        end
        FIFO_UNDERFLOW_COUNT: no_underflow_errors <= bus.datai[0];
        FIFO_CONFIG: {data_source_select, use_ddr} <= bus.datai[1:0];
        default: ;
      endcase
    end
  end

  // address and data of the single access
  always_ff @(posedge clk_usb) begin
    if (bus.write) begin
      case (bus.address)
        DDR_SINGLE_RW_DATA: begin
          if (bytecnt < 8)
            single_write_data[bytecnt*8 +: 8] <= bus.datai;
        end
        DDR_SINGLE_RW_ADDR: begin
          case (bytecnt)
            0: single_address[7:0]   <= bus.datai;
            1: single_address[15:8]  <= bus.datai;
            2: single_address[23:16] <= bus.datai;
            3: single_address[29:24] <= bus.datai[5:0];  // bit 7 is the direction
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

  // request levels, dropped by the returned done pulse
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      single_write <= 1'b0;
      single_read  <= 1'b0;
    end else if (mem_done) begin
      single_write <= 1'b0;
      single_read  <= 1'b0;
    end else if (bus.write && (bus.address == DDR_SINGLE_RW_ADDR) && (bytecnt == 3)) begin
      if (bus.datai[7])
        single_write <= 1'b1;
      else
        single_read <= 1'b1;
    end
  end

  assign mem_req.single_write = single_write;
  assign mem_req.single_read  = single_read;
  assign mem_req.address      = single_address;
  assign mem_req.write_data   = single_write_data;

  // one-shot, any other write drops it
  always_ff @(posedge clk_usb) begin
    if (reset)
      fast_fifo_read_mode <= 1'b0;
    else if (bus.write) begin
      if (bus.address == FAST_FIFO_READ_MODE)
        fast_fifo_read_mode <= bus.datai[0];
      else
        fast_fifo_read_mode <= 1'b0;
    end
  end

  always_ff @(posedge clk_usb) begin
    if (reset)
      clear_fifo_errors <= 1'b0;
    else
      clear_fifo_errors <= bus.write && (bus.address == FIFO_STAT) && bus.datai[0];
  end

  // one pop per ADCREAD burst
  assign adc_rd   = bus.read && (bus.address == ADCREAD);
  assign rd_first = adc_rd && !adc_rd_r;

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      adc_rd_r       <= 1'b0;
      fifo_rd_en_reg <= 1'b0;
    end else begin
      adc_rd_r       <= adc_rd;
      fifo_rd_en_reg <= rd_first && !fast_fifo_read_mode;  // normal mode pops a cycle late
    end
  end

  assign fifo_rd_en = fifo_rd_en_reg || (fast_fifo_read_mode && rd_first);

endmodule

`default_nettype wire

// File: hdl/sample_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sample_fifo #(
  parameter int FIFO_DEPTH_LOG2 = 4
) (
  input  wire                          clk_usb,
  input  wire                          reset,
  input  wire [7:0]                    adc_sample,
  input  wire                          adc_valid,
  input  wire                          rd_en,
  input  wire                          clear_errors,
  input  wire                          no_underflow_errors,
  output logic [7:0]                   head,
  output adcfifo_pkg::fifo_status_t    status
);

  logic [7:0]               mem [2**FIFO_DEPTH_LOG2];
  logic [FIFO_DEPTH_LOG2:0] wr_ptr;   // extra bit tells full from empty
  logic [FIFO_DEPTH_LOG2:0] rd_ptr;
  logic                     full;
  logic                     empty;
  logic                     push;
  logic                     pop;
  logic                     overflow_flag;
  logic                     underflow_flag;
  logic [7:0]               underflow_count;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2]) &&
                 (wr_ptr[FIFO_DEPTH_LOG2-1:0] == rd_ptr[FIFO_DEPTH_LOG2-1:0]);
  assign push  = adc_valid && !full;   // dropped when full
  assign pop   = rd_en && !empty;

  always_ff @(posedge clk_usb) begin
    if (push)
      mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= adc_sample;
  end

  assign head = mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // sticky error state, clear wins over a new event
  always_ff @(posedge clk_usb) begin
    if (reset || clear_errors) begin
      overflow_flag   <= 1'b0;
      underflow_flag  <= 1'b0;
      underflow_count <= 8'd0;
    end else begin
      if (adc_valid && full)
        overflow_flag <= 1'b1;
      if (rd_en && empty) begin
        underflow_flag <= 1'b1;
        if (!no_underflow_errors && (underflow_count != 8'hff))
          underflow_count <= underflow_count + 8'd1;
      end
    end
  end

  assign status = '{full: full, empty: empty, underflow_flag: underflow_flag,
                    overflow_flag: overflow_flag, underflow_count: underflow_count};

endmodule

`default_nettype wire

// File: hdl/ddr_single_access.sv
`timescale 1ns/10ps
`default_nettype none

module ddr_single_access #(
  parameter int MEM_ADDR_BITS = 4
) (
  input  wire                      ui_clk,
  input  wire                      reset,
  input  wire adcfifo_pkg::mem_req_t req,
  output logic [63:0]              read_data,
  output logic                     done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_DONE
  } state_e;

  state_e                   state;
  logic [1:0]               reset_sync;
  logic                     reset_ui;
  logic [1:0]               wr_sync;
  logic [1:0]               rd_sync;
  logic                     wr_prev;
  logic                     rd_prev;
  logic                     wr_edge;
  logic                     rd_edge;
  logic [63:0]              mem [2**MEM_ADDR_BITS];   // stands in for the DDR
  logic [MEM_ADDR_BITS-1:0] mem_addr;

  // reset crosses from clk_usb
  always_ff @(posedge ui_clk) begin
    reset_sync <= {reset_sync[0], reset};
  end

  assign reset_ui = reset_sync[1];

  always_ff @(posedge ui_clk) begin
    if (reset_ui) begin
      wr_sync <= 2'b00;
      rd_sync <= 2'b00;
      wr_prev <= 1'b0;
      rd_prev <= 1'b0;
    end else begin
      wr_sync <= {wr_sync[0], req.single_write};
      rd_sync <= {rd_sync[0], req.single_read};
      wr_prev <= wr_sync[1];
      rd_prev <= rd_sync[1];
    end
  end

  assign wr_edge  = wr_sync[1] && !wr_prev;
  assign rd_edge  = rd_sync[1] && !rd_prev;
  assign mem_addr = req.address[MEM_ADDR_BITS-1:0];  // upper address bits ignored

  // address and data held steady by the requester
  always_ff @(posedge ui_clk) begin
    if ((state == ST_IDLE) && wr_edge)
      mem[mem_addr] <= req.write_data;
    else if ((state == ST_IDLE) && rd_edge)
      read_data <= mem[mem_addr];  // kept until the next read
  end

  always_ff @(posedge ui_clk) begin
    if (reset_ui)
      state <= ST_IDLE;
    else begin
      case (state)
        ST_IDLE:   if (wr_edge || rd_edge) state <= ST_ACCESS;
        ST_ACCESS: state <= ST_DONE;
        ST_DONE:   state <= ST_IDLE;
        default:   state <= ST_IDLE;
      endcase
    end
  end

  assign done = (state == ST_DONE);  // two cycles after the edge

endmodule

`default_nettype wire

// File: hdl/adc_capture_top.sv
`timescale 1ns/10ps
`default_nettype none

module adc_capture_top #(
  parameter int BYTECNT_SIZE    = 7,
  parameter int FIFO_DEPTH_LOG2 = 4,
  parameter int MEM_ADDR_BITS   = 4
) (
  input  wire                        clk_usb,
  input  wire                        ui_clk,
  input  wire                        reset,
  input  wire adcfifo_pkg::reg_bus_t bus,
  output logic [7:0]                 reg_datao,
  input  wire [7:0]                  adc_sample,
  input  wire                        adc_valid,
  output logic                       low_res,
  output logic                       low_res_lsb,
  output logic [16:0]                stream_segment_threshold,
  output logic                       use_ddr,
  output logic                       data_source_select
);

  import adcfifo_pkg::*;

  fifo_status_t fifo_status;
  mem_req_t     mem_req;
  logic [7:0]   fifo_head;
  logic         fifo_rd_en;
  logic         clear_fifo_errors;
  logic         no_underflow_errors;
  logic [63:0]  mem_read_data;
  logic         mem_done_ui;
  logic         mem_done_usb;

  adcfifo_regs #(
    .BYTECNT_SIZE (BYTECNT_SIZE)
  ) u_regs (
    .clk_usb                  (clk_usb),
    .reset                    (reset),
    .bus                      (bus),
    .reg_datao                (reg_datao),
    .fifo_status              (fifo_status),
    .fifo_head                (fifo_head),
    .fifo_rd_en               (fifo_rd_en),
    .clear_fifo_errors        (clear_fifo_errors),
    .no_underflow_errors      (no_underflow_errors),
    .low_res                  (low_res),
    .low_res_lsb              (low_res_lsb),
    .stream_segment_threshold (stream_segment_threshold),
    .use_ddr                  (use_ddr),
    .data_source_select       (data_source_select),
    .mem_req                  (mem_req),
    .mem_read_data            (mem_read_data),
    .mem_done                 (mem_done_usb)
  );

  sample_fifo #(
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) u_fifo (
    .clk_usb             (clk_usb),
    .reset               (reset),
    .adc_sample          (adc_sample),
    .adc_valid           (adc_valid),
    .rd_en               (fifo_rd_en),
    .clear_errors        (clear_fifo_errors),
    .no_underflow_errors (no_underflow_errors),
    .head                (fifo_head),
    .status              (fifo_status)
  );

  // memory side runs on ui_clk
  ddr_single_access #(
    .MEM_ADDR_BITS (MEM_ADDR_BITS)
  ) u_mem (
    .ui_clk    (ui_clk),
    .reset     (reset),
    .req       (mem_req),
    .read_data (mem_read_data),
    .done      (mem_done_ui)
  );

  cdc_pulse u_done_cdc (
    .reset     (reset),
    .src_clk   (ui_clk),
    .src_pulse (mem_done_ui),
    .dst_clk   (clk_usb),
    .dst_pulse (mem_done_usb)
  );

endmodule

`default_nettype wire

// File: dv/adc_capture_checker.sv
`timescale 1ns/10ps
`default_nettype none

module adc_capture_checker (
  input  wire                        clk_usb,
  input  wire                        reset,
  input  wire adcfifo_pkg::reg_bus_t bus,
  input  wire [7:0]                  reg_datao,
  input  wire [7:0]                  adc_sample,
  input  wire                        adc_valid,
  input  wire                        low_res,
  input  wire                        low_res_lsb,
  input  wire [16:0]                 stream_segment_threshold,
  input  wire                        use_ddr,
  input  wire                        data_source_select,
  output int                         errors
);

  import adcfifo_pkg::*;

  localparam int FIFO_DEPTH      = 16;   // default FIFO_DEPTH_LOG2 of 4
  localparam int BUSY_MIN_CYCLES = 4;    // syncs both ways take longer than this
  localparam int BUSY_MAX_CYCLES = 20;

  logic [7:0]  fifo_q [$];
  logic [63:0] mem [16];            // only the low four address bits reach the array
  logic [15:0] mem_written;
  logic [63:0] rd_data;
  logic        rd_valid;
  logic [63:0] wr_data;
  logic [29:0] mem_addr;
  logic [1:0]  busy;                // {read, write}
  int          busy_age;            // clk_usb cycles since the request level rose
  logic [16:0] threshold;
  logic        low_res_m;
  logic        low_res_lsb_m;
  logic        use_ddr_m;
  logic        source_m;
  logic        no_uf;
  logic        fast;
  logic        ovf;
  logic        uf;
  logic [7:0]  uf_count;
  logic        rd_prev;
  logic        pend_pop;            // normal mode pops one cycle late
  logic        pend_clear;

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  task automatic check_read();
    reg_addr_e   a;
    logic [7:0]  exp;
    logic        known;
    logic [23:0] thr_bytes;
    a         = reg_addr_e'(bus.address);
    exp       = 8'h00;
    known     = 1'b1;
    thr_bytes = {7'b0, threshold};
    case (a)
      FIFO_STAT: exp = {4'b0, fifo_q.size() == FIFO_DEPTH, ovf, uf, fifo_q.size() == 0};
      ADCREAD: begin
        known = (fifo_q.size() != 0);  // stale head when empty
        if (known)
          exp = fifo_q[0];
      end
      FAST_FIFO_READ_MODE: exp = {7'b0, fast};
      STREAM_SEGMENT_THRESHOLD: begin
        if (bus.bytecnt < 3)
          exp = thr_bytes[bus.bytecnt*8 +: 8];
      end
      ADC_LOW_RES: exp = {6'b0, low_res_lsb_m, low_res_m};
      FIFO_UNDERFLOW_COUNT: exp = uf_count;
      FIFO_CONFIG: exp = {6'b0, source_m, use_ddr_m};
      DDR_SINGLE_RW_DATA: begin
        known = rd_valid;
        if (bus.bytecnt < 8)
          exp = rd_data[bus.bytecnt*8 +: 8];
      end
      DDR_SINGLE_RW_ADDR: begin
        // completion lands somewhere inside the synchronizer window
        if ((busy_age > BUSY_MAX_CYCLES) ||
            ((busy_age > BUSY_MIN_CYCLES) && (reg_datao == 8'h00)))
          busy = 2'b00;
        exp = {6'b0, busy};
      end
      default: known = 1'b0;
    endcase
    if (known)
      compare_value(a.name(), {56'b0, exp}, {56'b0, reg_datao});
  endtask

  task automatic start_access(input logic is_write);
    logic [3:0] idx;
    idx      = mem_addr[3:0];
    busy     = is_write ? 2'b01 : 2'b10;
    busy_age = 0;
    if (is_write) begin
      mem[idx]         = wr_data;
      mem_written[idx] = 1'b1;
    end else begin
      rd_data  = mem[idx];
      rd_valid = mem_written[idx];  // unwritten words hold no known value
    end
  endtask

  task automatic apply_write();
    fast = (bus.address == FAST_FIFO_READ_MODE) ? bus.datai[0] : 1'b0;
    case (bus.address)
      ADC_LOW_RES: {low_res_lsb_m, low_res_m} = bus.datai[1:0];
      STREAM_SEGMENT_THRESHOLD: begin
        case (bus.bytecnt)
          7'd0: threshold[7:0] = bus.datai;
          7'd1: threshold[15:8] = bus.datai;
          7'd2: threshold[16] = bus.datai[0];
          default: ;
        endcase
      end
      FIFO_UNDERFLOW_COUNT: no_uf = bus.datai[0];
      FIFO_CONFIG: {source_m, use_ddr_m} = bus.datai[1:0];
      DDR_SINGLE_RW_DATA: begin
        if (bus.bytecnt < 8)
          wr_data[bus.bytecnt*8 +: 8] = bus.datai;
      end
      DDR_SINGLE_RW_ADDR: begin
        case (bus.bytecnt)
          7'd0: mem_addr[7:0] = bus.datai;
          7'd1: mem_addr[15:8] = bus.datai;
          7'd2: mem_addr[23:16] = bus.datai;
          7'd3: begin
            mem_addr[29:24] = bus.datai[5:0];
            start_access(bus.datai[7]);  // bit 7 picks write
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  endtask

  task automatic update_model();
    logic rd;
    logic first;
    logic pop_now;
    logic was_full;
    logic was_empty;
    rd        = bus.read && (bus.address == ADCREAD);
    first     = rd && !rd_prev;
    pop_now   = pend_pop || (fast && first);
    was_full  = (fifo_q.size() == FIFO_DEPTH);
    was_empty = (fifo_q.size() == 0);
    if (pop_now) begin
      if (was_empty) begin
        uf = 1'b1;
        if (!no_uf && (uf_count != 8'hff))
          uf_count++;
      end else
        void'(fifo_q.pop_front());
    end
    if (adc_valid) begin
      if (was_full)
        ovf = 1'b1;  // sample lost
      else
        fifo_q.push_back(adc_sample);
    end
    if (pend_clear) begin
      ovf      = 1'b0;
      uf       = 1'b0;
      uf_count = 8'd0;
    end
    pend_pop   = first && !fast;
    rd_prev    = rd;
    pend_clear = bus.write && (bus.address == FIFO_STAT) && bus.datai[0];
    if (bus.write)
      apply_write();
  endtask

  // outputs settle half a cycle after the driving edge
  always @(negedge clk_usb) begin
    if (reset) begin
      fifo_q.delete();
      mem_written   = '0;
      rd_valid      = 1'b0;
      busy          = 2'b00;
      busy_age      = 0;
      threshold     = SEGMENT_THRESHOLD_RESET;
      low_res_m     = 1'b0;
      low_res_lsb_m = 1'b0;
      use_ddr_m     = 1'b1;
      source_m      = 1'b1;
      no_uf         = 1'b0;
      fast          = 1'b0;
      ovf           = 1'b0;
      uf            = 1'b0;
      uf_count      = 8'd0;
      rd_prev       = 1'b0;
      pend_pop      = 1'b0;
      pend_clear    = 1'b0;
      errors        = 0;
    end else begin
      if (busy != 2'b00)
        busy_age++;
      if (bus.read)
        check_read();
      compare_value("low_res", {63'b0, low_res_m}, {63'b0, low_res});
      compare_value("low_res_lsb", {63'b0, low_res_lsb_m}, {63'b0, low_res_lsb});
      compare_value("stream_segment_threshold", {47'b0, threshold},
                    {47'b0, stream_segment_threshold});
      compare_value("use_ddr", {63'b0, use_ddr_m}, {63'b0, use_ddr});
      compare_value("data_source_select", {63'b0, source_m}, {63'b0, data_source_select});
      update_model();
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_adc_capture.sv
`timescale 1ns/10ps
`default_nettype none

module tb_adc_capture;

  import adcfifo_pkg::*;

  localparam int DIRECTED_OPS = 400;
  localparam int RANDOM_OPS   = 500;
  localparam int WATCHDOG_NS  = (DIRECTED_OPS + RANDOM_OPS) * 400;
  localparam int POLL_LIMIT   = 50;
  localparam int FILL_COUNT   = 18;   // two more than the FIFO holds

  logic        clk_usb;
  logic        ui_clk;
  logic        reset;
  reg_bus_t    bus;
  logic [7:0]  reg_datao;
  logic [7:0]  adc_sample;
  logic        adc_valid;
  logic        low_res;
  logic        low_res_lsb;
  logic [16:0] stream_segment_threshold;
  logic        use_ddr;
  logic        data_source_select;
  int          check_errors;
  int          tb_errors;
  integer      seed;
  logic        fast_on;   // stimulus copy of fast mode, keeps bursts to one read
  logic [7:0]  read_sink;  // sink for reads checked by the checker

  adc_capture_top uut (
    .clk_usb                  (clk_usb),
    .ui_clk                   (ui_clk),
    .reset                    (reset),
    .bus                      (bus),
    .reg_datao                (reg_datao),
    .adc_sample               (adc_sample),
    .adc_valid                (adc_valid),
    .low_res                  (low_res),
    .low_res_lsb              (low_res_lsb),
    .stream_segment_threshold (stream_segment_threshold),
    .use_ddr                  (use_ddr),
    .data_source_select       (data_source_select)
  );

  adc_capture_checker chk (
    .clk_usb                  (clk_usb),
    .reset                    (reset),
    .bus                      (bus),
    .reg_datao                (reg_datao),
    .adc_sample               (adc_sample),
    .adc_valid                (adc_valid),
    .low_res                  (low_res),
    .low_res_lsb              (low_res_lsb),
    .stream_segment_threshold (stream_segment_threshold),
    .use_ddr                  (use_ddr),
    .data_source_select       (data_source_select),
    .errors                   (check_errors)
  );

  initial begin
    clk_usb = 1'b0;
    forever #5 clk_usb = ~clk_usb;
  end

  initial begin
    ui_clk = 1'b0;
    forever #6.5 ui_clk = ~ui_clk;  // unrelated to clk_usb
  end

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // readable registers apart from ADCREAD, which would pop
  function automatic logic [7:0] reg_at(input int i);
    case (i)
      0: return FIFO_STAT;
      1: return FAST_FIFO_READ_MODE;
      2: return STREAM_SEGMENT_THRESHOLD;
      3: return ADC_LOW_RES;
      4: return FIFO_UNDERFLOW_COUNT;
      5: return FIFO_CONFIG;
      6: return DDR_SINGLE_RW_DATA;
      default: return DDR_SINGLE_RW_ADDR;
    endcase
  endfunction

  task automatic drive_idle();
    @(posedge clk_usb);
    bus       <= '0;
    adc_valid <= 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [6:0] bc, input logic [7:0] data);
    @(posedge clk_usb);
    bus       <= '{address: addr, bytecnt: bc, datai: data, read: 1'b0, write: 1'b1};
    adc_valid <= 1'b0;
    fast_on    = (addr == FAST_FIFO_READ_MODE) && data[0];
    drive_idle();
  endtask

  task automatic read_reg(input logic [7:0] addr, input logic [6:0] bc, output logic [7:0] data);
    @(posedge clk_usb);
    bus       <= '{address: addr, bytecnt: bc, datai: 8'h00, read: 1'b1, write: 1'b0};
    adc_valid <= 1'b0;
    @(negedge clk_usb);
    data = reg_datao;
  endtask

  task automatic push_sample(input logic [7:0] value);
    @(posedge clk_usb);
    bus        <= '0;
    adc_valid  <= 1'b1;
    adc_sample <= value;
  endtask

  task automatic adc_burst(input int len);
    logic [7:0] d;
    for (int i = 0; i < len; i++)
      read_reg(ADCREAD, 7'd0, d);
    drive_idle();
  endtask

  task automatic read_config();
    logic [7:0] d;
    for (int i = 0; i < 8; i++) begin
      read_reg(reg_at(i), 7'd0, d);
      drive_idle();
    end
    for (int b = 1; b < 3; b++) begin
      read_reg(STREAM_SEGMENT_THRESHOLD, 7'(b), d);
      drive_idle();
    end
  endtask

  task automatic write_config();
    case (rand_below(5))
      0: write_reg(ADC_LOW_RES, 7'd0, 8'(rand_below(256)));
      1: write_reg(FIFO_CONFIG, 7'd0, 8'(rand_below(256)));
      2: write_reg(FIFO_UNDERFLOW_COUNT, 7'd0, 8'(rand_below(4)));
      3: write_reg(STREAM_SEGMENT_THRESHOLD, 7'(rand_below(3)), 8'(rand_below(256)));
      default: write_reg(FAST_FIFO_READ_MODE, 7'd0, 8'(rand_below(2)));
    endcase
  endtask

  task automatic mem_access(input logic is_write, input logic [3:0] addr,
                            input logic [63:0] data);
    int         tries;
    logic [7:0] status;
    logic [7:0] d;
    if (is_write)
      for (int i = 0; i < 8; i++)
        write_reg(DDR_SINGLE_RW_DATA, 7'(i), data[i*8 +: 8]);
    write_reg(DDR_SINGLE_RW_ADDR, 7'd0, {4'(rand_below(16)), addr});
    write_reg(DDR_SINGLE_RW_ADDR, 7'd1, 8'(rand_below(256)));  // upper bits are ignored
    write_reg(DDR_SINGLE_RW_ADDR, 7'd2, 8'(rand_below(256)));
    write_reg(DDR_SINGLE_RW_ADDR, 7'd3, {is_write, 1'b0, 6'(rand_below(64))});
    tries = 0;
    do begin
      read_reg(DDR_SINGLE_RW_ADDR, 7'd0, status);
      drive_idle();
      tries++;
    end while ((status[1:0] != 2'b00) && (tries < POLL_LIMIT));
    if (status[1:0] != 2'b00) begin
      tb_errors++;
      $display("single access to address %0d still busy after %0d polls", addr, tries);
    end
    if (!is_write) begin
      for (int i = 0; i < 8; i++)
        read_reg(DDR_SINGLE_RW_DATA, 7'(i), d);
      drive_idle();
    end
  endtask

  initial begin
    seed       = 32'h047c0684;
    tb_errors  = 0;
    fast_on    = 1'b0;
    reset      = 1'b1;
    bus        = '0;
    adc_sample = 8'h00;
    adc_valid  = 1'b0;
    repeat (10) @(posedge clk_usb);
    reset <= 1'b0;
    read_config();
    write_reg(STREAM_SEGMENT_THRESHOLD, 7'd1, 8'h5a);  // middle byte only
    write_reg(ADC_LOW_RES, 7'd0, 8'h03);
    write_reg(FIFO_CONFIG, 7'd0, 8'h00);
    read_config();
    for (int i = 0; i < 3; i++)
      push_sample(8'(160 + i));
    drive_idle();
    adc_burst(2);
    adc_burst(3);
    write_reg(FAST_FIFO_READ_MODE, 7'd0, 8'h01);
    adc_burst(1);
    write_reg(FIFO_CONFIG, 7'd0, 8'h03);  // drops fast mode
    read_config();
    repeat (FILL_COUNT) push_sample(8'(rand_below(256)));
    drive_idle();
    read_config();
    repeat (280) adc_burst(1);  // drain, then saturate the count
    read_config();
    write_reg(FIFO_STAT, 7'd0, 8'h01);
    read_config();
    write_reg(FIFO_UNDERFLOW_COUNT, 7'd0, 8'h01);
    repeat (3) adc_burst(1);
    read_config();
    write_reg(FIFO_UNDERFLOW_COUNT, 7'd0, 8'h00);
    mem_access(1'b1, 4'd5, {$random(seed), $random(seed)});
    mem_access(1'b0, 4'd5, 64'd0);

    for (int n = 0; n < RANDOM_OPS; n++) begin
      case (rand_below(6))
        0: begin
          repeat (1 + rand_below(3)) push_sample(8'(rand_below(256)));
          drive_idle();
        end
        1: adc_burst(fast_on ? 1 : 1 + rand_below(3));
        2: write_config();
        3: begin
          read_reg(reg_at(rand_below(8)), 7'(rand_below(8)), read_sink);
          drive_idle();
        end
        4: write_reg(FIFO_STAT, 7'd0, 8'(rand_below(4)));
        default: mem_access(1'(rand_below(2)), 4'(rand_below(16)),
                            {$random(seed), $random(seed)});
      endcase
    end

    drive_idle();
    repeat (2) @(posedge clk_usb);
    $display("errors: checker %0d, testbench %0d", check_errors, tb_errors);
    if ((check_errors + tb_errors) == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run hung", WATCHDOG_NS);
    $display("errors: checker %0d, testbench %0d", check_errors, tb_errors);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
hdl/adcfifo_pkg.sv
hdl/cdc_pulse.sv
hdl/adcfifo_regs.sv
hdl/sample_fifo.sv
hdl/ddr_single_access.sv
hdl/adc_capture_top.sv
dv/adc_capture_checker.sv
dv/tb_adc_capture.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_adc_capture
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it and look for the pass message"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx '** PASS **'

clean:
	rm -rf $(BUILD_DIR)
